/* run_sim.sh */
#!/bin/bash
# Build and run the tile layer testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_tile_layer \
  -f sources.f -o tb_tile_layer_sim > build.log 2>&1 \
  && ./obj_dir/tb_tile_layer_sim > sim.log 2>&1 \
  || { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }
grep -q "tests failed" sim.log && { echo "Simulation reported failures"; exit 1; }
echo "Simulation passed"
exit 0

/* sources.f */
tile_pkg.sv
tile_reg_file.sv
tile_reg_decoder.sv
tile_addr_gen.sv
tile_map_out.sv
tile_layer_top.sv
tile_layer_chk.sv
tb_tile_layer.sv

/* tb_tile_layer.sv */
// Tile layer testbench
`timescale 1ns/100ps

module tb_tile_layer;
  import tile_pkg::*;

  typedef struct packed {
    layer_t     layer;
    logic       hit;
    vram_addr_t addr;
    logic [3:0] pix_x;
    logic [3:0] pix_y;
  } result_t;

  logic          clk = 1'b0;
  logic          rst = 1'b1;
  logic          reg_wr = 1'b0;
  layer_t        reg_layer = '0;
  reg_index_t    reg_index = '0;
  reg_data_t     reg_wdata = '0;
  reg_data_t     reg_rdata;
  logic          req = 1'b0;
  layer_t        req_layer = '0;
  screen_coord_t req_x = '0;
  screen_coord_t req_y = '0;
  logic          out_valid;
  layer_t        out_layer;
  logic          out_hit;
  vram_addr_t    out_map_addr;
  logic [3:0]    out_pix_x;
  logic [3:0]    out_pix_y;
  reg_data_t     model [NUM_TILE_LAYERS][NUM_TILE_REGS];
  result_t       exp_q [$];
  logic [15:0]   lfsr = 16'd62455;
  int            errors = 0;
  int            failures = 0;

  tile_layer_top #(.NUM_LAYERS(NUM_TILE_LAYERS)) dut0 (.*);

  always #10 clk = ~clk;

  // Galois LFSR stepped once for every bit taken
  function automatic logic [15:0] rand_bits(int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      v = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  // Reference model that works the map address out in plain integers
  function automatic result_t expected_result(layer_t l, screen_coord_t x, screen_coord_t y);
    reg_data_t c0;
    int        hs;
    int        vs;
    int        sx;
    int        sy;
    int        doff;
    result_t   r;
    c0 = model[l][TILE_CTRL0];
    hs = int'(model[l][TILE_CTRL1][1:0]);
    vs = int'(model[l][TILE_CTRL1][3:2]);
    sx = int'(x);
    sy = int'(y);
    if (c0[TILE_ENABLE_SCROLL]) begin
      sx = (sx + int'(model[l][TILE_OFFSET_X])) % 65536;
      sy = (sy + int'(model[l][TILE_OFFSET_Y])) % 65536;
    end
    r.hit = c0[TILE_LAYER_ENABLED];
    // A size code 0 map is 512 pixels on a side
    if (c0[TILE_ENABLE_WRAP_X]) begin
      sx = sx % (512 << hs);
    end else if (sx >= (512 << hs)) begin
      r.hit = 1'b0;
    end
    if (c0[TILE_ENABLE_WRAP_Y]) begin
      sy = sy % (512 << vs);
    end else if (sy >= (512 << vs)) begin
      r.hit = 1'b0;
    end
    doff = int'(model[l][TILE_DATA_OFFSET]);
    if (c0[TILE_SHIFT_DATA_OFFSET]) begin
      doff = (doff * 16) % 65536;
    end
    r.layer = l;
    r.addr  = vram_addr_t'((doff + (sy / 16) * (32 << hs) + sx / 16) % 65536);
    r.pix_x = 4'(sx % 16);
    r.pix_y = 4'(sy % 16);
    return r;
  endfunction

  task automatic check(string name, logic [15:0] actual, logic [15:0] expected);
    if (actual !== expected) begin
      $display("ERR %0t: %s is %h, expected %h", $time, name, actual, expected);
      errors++;
    end
  endtask

  // One clock of stimulus plus a readback check of the addressed register
  task automatic drive_cycle(logic wr, layer_t wl, reg_index_t wi, reg_data_t wd,
                             logic rq, layer_t rl, screen_coord_t rx, screen_coord_t ry);
    @(negedge clk);
    reg_wr    = wr;
    reg_layer = wl;
    reg_index = wi;
    reg_wdata = wd;
    req       = rq;
    req_layer = rl;
    req_x     = rx;
    req_y     = ry;
    // A request sees the registers as they were before this cycle's write
    if (rq) begin
      exp_q.push_back(expected_result(rl, rx, ry));
    end
    #5;
    check("reg_rdata", reg_rdata, (wi < 3'd5) ? model[wl][wi] : '0);
    if (wr && (wi < 3'd5)) begin
      model[wl][wi] = wd;
    end
  endtask

  task automatic apply_reset();
    rst    = 1'b1;
    reg_wr = 1'b0;
    req    = 1'b0;
    foreach (model[l, i]) begin
      model[l][i] = '0;
    end
    repeat (5) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while ((exp_q.size() != 0) && (waited < 10)) begin
      drive_cycle(1'b0, '0, '0, '0, 1'b0, '0, '0, '0);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout: no output arrived for %0d pending requests", exp_q.size());
      failures++;
      exp_q.delete();
    end
  endtask

  // Outputs change on the rising edge and are read on the falling one
  always @(negedge clk) begin : monitor
    result_t e;
    if ((rst === 1'b0) && (out_valid === 1'b1)) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected output at %0t: out_valid with no request pending", $time);
        failures++;
      end else begin
        e = exp_q.pop_front();
        check("out_layer", out_layer, e.layer);
        check("out_hit", out_hit, e.hit);
        check("out_map_addr", out_map_addr, e.addr);
        check("out_pix_x", out_pix_x, e.pix_x);
        check("out_pix_y", out_pix_y, e.pix_y);
      end
    end
  end

  initial begin
    apply_reset();
    // Random writes over all indices where 5 to 7 must keep reading zero
    repeat (80) begin
      drive_cycle(1'b1, layer_t'(rand_bits(2)), reg_index_t'(rand_bits(3)), rand_bits(16),
                  1'b0, '0, '0, '0);
    end
    apply_reset();
    repeat (24) begin
      drive_cycle(1'b0, layer_t'(rand_bits(2)), reg_index_t'(rand_bits(3)), '0,
                  1'b0, '0, '0, '0);
    end
    // Writes and requests mixed at random and often in the same cycle
    repeat (400) begin
      drive_cycle(rand_bits(1) != 0, layer_t'(rand_bits(2)), reg_index_t'(rand_bits(3)),
                  rand_bits(16), rand_bits(2) != 0, layer_t'(rand_bits(2)),
                  screen_coord_t'(rand_bits(10)), screen_coord_t'(rand_bits(10)));
    end
    drain();
    // Every hsize and vsize pair on layer 2 under random CTRL0 flags
    for (int c = 0; c < 64; c++) begin
      drive_cycle(1'b1, 2'd2, TILE_CTRL1, reg_data_t'(c % 16), 1'b0, '0, '0, '0);
      drive_cycle(1'b1, 2'd2, TILE_CTRL0, rand_bits(16), 1'b1, 2'd2,
                  screen_coord_t'(rand_bits(10)), screen_coord_t'(rand_bits(10)));
    end
    drain();
    // Alternating layers every cycle while their scroll is rewritten
    drive_cycle(1'b1, 2'd0, TILE_CTRL0, 16'h0189, 1'b0, '0, '0, '0);
    drive_cycle(1'b1, 2'd1, TILE_CTRL0, 16'h0189, 1'b0, '0, '0, '0);
    for (int k = 0; k < 12; k++) begin
      drive_cycle(1'b1, layer_t'(k % 2), TILE_OFFSET_X, rand_bits(16), 1'b1, layer_t'(k % 2),
                  screen_coord_t'(rand_bits(10)), screen_coord_t'(rand_bits(10)));
    end
    drain();
    $display("Summary: %0d value mismatches, %0d other failures", errors, failures);
    if ((errors == 0) && (failures == 0)) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* tile_addr_gen.sv */
// Tile scroll and wrap stage
`timescale 1ns/100ps

module tile_addr_gen (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    req,
  input  tile_pkg::layer_t        req_layer,
  input  tile_pkg::screen_coord_t req_x,
  input  tile_pkg::screen_coord_t req_y,
  input  tile_pkg::reg_data_t     offset_x,
  input  tile_pkg::reg_data_t     offset_y,
  input  logic                    layer_enabled,
  input  logic                    enable_scroll,
  input  logic                    enable_wrap_x,
  input  logic                    enable_wrap_y,
  input  tile_pkg::size_enum_t    tile_hsize_enum,
  input  tile_pkg::size_enum_t    tile_vsize_enum,
  input  tile_pkg::vram_addr_t    data_offset,
  output logic                    s1_valid,
  output tile_pkg::layer_t        s1_layer,
  output tile_pkg::coord_t        s1_x,
  output tile_pkg::coord_t        s1_y,
  output logic                    s1_hit,
  output tile_pkg::size_enum_t    s1_hsize,
  output tile_pkg::vram_addr_t    s1_data_offset
);
  import tile_pkg::*;

  // Map edge in pixels for size code 0
  localparam int MAP_PIX_LOG2 = TILE_MAP_BASE_LOG2 + TILE_SIZE_LOG2;

  coord_t scroll_x;
  coord_t scroll_y;
  coord_t map_w;
  coord_t map_h;
  coord_t fold_x;
  coord_t fold_y;
  logic   in_x;
  logic   in_y;
  logic   hit;

  // Scroll sums wrap at 16 bits just like the hardware adder
  assign scroll_x = coord_t'(req_x) + (enable_scroll ? coord_t'(offset_x) : coord_t'(0));
  assign scroll_y = coord_t'(req_y) + (enable_scroll ? coord_t'(offset_y) : coord_t'(0));

  assign map_w = coord_t'(1) << (MAP_PIX_LOG2 + int'(tile_hsize_enum));
  assign map_h = coord_t'(1) << (MAP_PIX_LOG2 + int'(tile_vsize_enum));

  assign in_x = scroll_x < map_w;
  assign in_y = scroll_y < map_h;

  // Map sizes are powers of two, so the modulo is a mask
  assign fold_x = enable_wrap_x ? (scroll_x & (map_w - coord_t'(1))) : scroll_x;
  assign fold_y = enable_wrap_y ? (scroll_y & (map_h - coord_t'(1))) : scroll_y;

  assign hit = layer_enabled && (enable_wrap_x || in_x) && (enable_wrap_y || in_y);

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= req;
    end
  end

  // Everything stage 2 needs is captured here, later writes cannot reach it
  always_ff @(posedge clk) begin
    if (req) begin
      s1_layer       <= req_layer;
      s1_x           <= fold_x;
      s1_y           <= fold_y;
      s1_hit         <= hit;
      s1_hsize       <= tile_hsize_enum;
      s1_data_offset <= data_offset;
    end
  end

endmodule

/* tile_layer_chk.sv */
// Tile layer output assertions
`timescale 1ns/100ps

module tile_layer_chk (
  input logic                                clk,
  input logic                                rst,
  input logic                                req,
  input logic                                out_valid,
  input logic                                out_hit,
  input logic [tile_pkg::TILE_SIZE_LOG2-1:0] out_pix_x,
  input logic [tile_pkg::TILE_SIZE_LOG2-1:0] out_pix_y
);
  import tile_pkg::*;

  // Two register stages sit between a request and its result
  a_latency: assert property (@(posedge clk) disable iff (rst) out_valid == $past(req, 2))
    else $error("out_valid does not follow req by exactly two cycles");

  a_reset_flush: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high during or right after reset");

  a_pix_range: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> !$isunknown({out_pix_x, out_pix_y}) &&
      (int'(out_pix_x) < (1 << TILE_SIZE_LOG2)) && (int'(out_pix_y) < (1 << TILE_SIZE_LOG2)))
    else $error("Pixel position outside the tile");

  a_hit_valid: assert property (@(posedge clk) disable iff (rst) out_hit |-> out_valid)
    else $error("out_hit without out_valid");

endmodule

bind tile_layer_top tile_layer_chk chk0 (
  .clk       (clk),
  .rst       (rst),
  .req       (req),
  .out_valid (out_valid),
  .out_hit   (out_hit),
  .out_pix_x (out_pix_x),
  .out_pix_y (out_pix_y)
);

/* tile_layer_top.sv */
// Tile layer register and map address top
`timescale 1ns/100ps

module tile_layer_top #(
  parameter int NUM_LAYERS = tile_pkg::NUM_TILE_LAYERS
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                reg_wr,
  input  tile_pkg::layer_t                    reg_layer,
  input  tile_pkg::reg_index_t                reg_index,
  input  tile_pkg::reg_data_t                 reg_wdata,
  output tile_pkg::reg_data_t                 reg_rdata,
  input  logic                                req,
  input  tile_pkg::layer_t                    req_layer,
  input  tile_pkg::screen_coord_t             req_x,
  input  tile_pkg::screen_coord_t             req_y,
  output logic                                out_valid,
  output tile_pkg::layer_t                    out_layer,
  output logic                                out_hit,
  output tile_pkg::vram_addr_t                out_map_addr,
  output logic [tile_pkg::TILE_SIZE_LOG2-1:0] out_pix_x,
  output logic [tile_pkg::TILE_SIZE_LOG2-1:0] out_pix_y
);
  import tile_pkg::*;

  reg_data_t  ctrl0;
  reg_data_t  ctrl1;
  reg_data_t  data_offset_raw;
  reg_data_t  offset_x;
  reg_data_t  offset_y;
  logic       layer_enabled;
  logic       enable_scroll;
  logic       enable_wrap_x;
  logic       enable_wrap_y;
  size_enum_t tile_hsize_enum;
  size_enum_t tile_vsize_enum;
  vram_addr_t data_offset;
  logic       s1_valid;
  layer_t     s1_layer;
  coord_t     s1_x;
  coord_t     s1_y;
  logic       s1_hit;
  size_enum_t s1_hsize;
  vram_addr_t s1_data_offset;

  // The request layer picks the register set in the request cycle
  tile_reg_file #(.NUM_LAYERS(NUM_LAYERS)) u_reg_file (
    .clk             (clk),
    .rst             (rst),
    .reg_wr          (reg_wr),
    .reg_layer       (reg_layer),
    .reg_index       (reg_index),
    .reg_wdata       (reg_wdata),
    .reg_rdata       (reg_rdata),
    .sel_layer       (req_layer),
    .ctrl0           (ctrl0),
    .ctrl1           (ctrl1),
    .data_offset_raw (data_offset_raw),
    .offset_x        (offset_x),
    .offset_y        (offset_y)
  );

  tile_reg_decoder #(.NUM_LAYERS(NUM_LAYERS)) u_decoder (
    .ctrl0           (ctrl0),
    .ctrl1           (ctrl1),
    .data_offset_raw (data_offset_raw),
    .layer_enabled   (layer_enabled),
    .enable_scroll   (enable_scroll),
    .enable_wrap_x   (enable_wrap_x),
    .enable_wrap_y   (enable_wrap_y),
    .tile_hsize_enum (tile_hsize_enum),
    .tile_vsize_enum (tile_vsize_enum),
    .data_offset     (data_offset)
  );

  tile_addr_gen u_addr_gen (
    .clk             (clk),
    .rst             (rst),
    .req             (req),
    .req_layer       (req_layer),
    .req_x           (req_x),
    .req_y           (req_y),
    .offset_x        (offset_x),
    .offset_y        (offset_y),
    .layer_enabled   (layer_enabled),
    .enable_scroll   (enable_scroll),
    .enable_wrap_x   (enable_wrap_x),
    .enable_wrap_y   (enable_wrap_y),
    .tile_hsize_enum (tile_hsize_enum),
    .tile_vsize_enum (tile_vsize_enum),
    .data_offset     (data_offset),
    .s1_valid        (s1_valid),
    .s1_layer        (s1_layer),
    .s1_x            (s1_x),
    .s1_y            (s1_y),
    .s1_hit          (s1_hit),
    .s1_hsize        (s1_hsize),
    .s1_data_offset  (s1_data_offset)
  );

  tile_map_out u_map_out (
    .clk             (clk),
    .rst             (rst),
    .s1_valid        (s1_valid),
    .s1_layer        (s1_layer),
    .s1_x            (s1_x),
    .s1_y            (s1_y),
    .s1_hit          (s1_hit),
    .s1_hsize        (s1_hsize),
    .s1_data_offset  (s1_data_offset),
    .out_valid       (out_valid),
    .out_layer       (out_layer),
    .out_hit         (out_hit),
    .out_map_addr    (out_map_addr),
    .out_pix_x       (out_pix_x),
    .out_pix_y       (out_pix_y)
  );

endmodule

/* tile_map_out.sv */
// Tile map address output stage
`timescale 1ns/100ps

module tile_map_out (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                s1_valid,
  input  tile_pkg::layer_t                    s1_layer,
  input  tile_pkg::coord_t                    s1_x,
  input  tile_pkg::coord_t                    s1_y,
  input  logic                                s1_hit,
  input  tile_pkg::size_enum_t                s1_hsize,
  input  tile_pkg::vram_addr_t                s1_data_offset,
  output logic                                out_valid,
  output tile_pkg::layer_t                    out_layer,
  output logic                                out_hit,
  output tile_pkg::vram_addr_t                out_map_addr,
  output logic [tile_pkg::TILE_SIZE_LOG2-1:0] out_pix_x,
  output logic [tile_pkg::TILE_SIZE_LOG2-1:0] out_pix_y
);
  import tile_pkg::*;

  coord_t     col;
  coord_t     row;
  vram_addr_t row_base;
  vram_addr_t map_addr;

  assign col = s1_x >> TILE_SIZE_LOG2;
  assign row = s1_y >> TILE_SIZE_LOG2;

  // Row stride is the map width in tiles, 32 shifted by the size code
  assign row_base = vram_addr_t'(row << (TILE_MAP_BASE_LOG2 + int'(s1_hsize)));
  assign map_addr = s1_data_offset + row_base + vram_addr_t'(col);

  // Hit is qualified here so it never outlives its valid cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      out_hit   <= 1'b0;
    end else begin
      out_valid <= s1_valid;
      out_hit   <= s1_valid && s1_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      out_layer    <= s1_layer;
      out_map_addr <= map_addr;
      out_pix_x    <= s1_x[TILE_SIZE_LOG2-1:0];
      out_pix_y    <= s1_y[TILE_SIZE_LOG2-1:0];
    end
  end

endmodule

/* tile_pkg.sv */
// Tile layer shared definitions
package tile_pkg;

  // Vector types for the widths that carry a meaning
  typedef logic [15:0] reg_data_t;
  typedef logic [15:0] vram_addr_t;
  typedef logic [15:0] coord_t;
  typedef logic [9:0]  screen_coord_t;
  typedef logic [1:0]  layer_t;
  typedef logic [1:0]  size_enum_t;
  typedef logic [2:0]  reg_index_t;

  localparam int NUM_TILE_REGS   = 5;
  localparam int NUM_TILE_LAYERS = 4;

  // Register word indices within one layer
  localparam reg_index_t TILE_CTRL0       = 3'd0;
  localparam reg_index_t TILE_CTRL1       = 3'd1;
  localparam reg_index_t TILE_DATA_OFFSET = 3'd2;
  localparam reg_index_t TILE_OFFSET_X    = 3'd3;
  localparam reg_index_t TILE_OFFSET_Y    = 3'd4;

  // CTRL0 bit positions, only the ones this block decodes
  localparam int TILE_LAYER_ENABLED     = 0;
  localparam int TILE_ENABLE_SCROLL     = 3;
  localparam int TILE_ENABLE_WRAP_X     = 7;
  localparam int TILE_ENABLE_WRAP_Y     = 8;
  localparam int TILE_SHIFT_DATA_OFFSET = 10;

  // CTRL1 map size fields
  localparam int TILE_HSIZE_0 = 0;
  localparam int TILE_HSIZE_1 = 1;
  localparam int TILE_VSIZE_0 = 2;
  localparam int TILE_VSIZE_1 = 3;

  localparam int TILE_DATA_OFFSET_SHIFT = 4;

  // Tiles are 16x16 pixels
  localparam int TILE_SIZE_LOG2 = 4;

  // Smallest map is 32 tiles on a side, the size code shifts it up
  localparam int TILE_MAP_BASE_LOG2 = 5;

endpackage

/* tile_reg_decoder.sv */
// Tile layer register field decoder
`timescale 1ns/100ps

module tile_reg_decoder #(
  parameter int NUM_LAYERS = tile_pkg::NUM_TILE_LAYERS
) (
  input  tile_pkg::reg_data_t  ctrl0,
  input  tile_pkg::reg_data_t  ctrl1,
  input  tile_pkg::reg_data_t  data_offset_raw,
  output logic                 layer_enabled,
  output logic                 enable_scroll,
  output logic                 enable_wrap_x,
  output logic                 enable_wrap_y,
  output tile_pkg::size_enum_t tile_hsize_enum,
  output tile_pkg::size_enum_t tile_vsize_enum,
  output tile_pkg::vram_addr_t data_offset
);
  import tile_pkg::*;

  logic shift_data_offset;

  // The layer select is only two bits wide, so more than four layers
  // cannot be addressed
  if ((NUM_LAYERS < 1) || (NUM_LAYERS > NUM_TILE_LAYERS)) begin : g_layer_range
    $error("NUM_LAYERS must be between 1 and %0d", NUM_TILE_LAYERS);
  end

  assign layer_enabled     = ctrl0[TILE_LAYER_ENABLED];
  assign enable_scroll     = ctrl0[TILE_ENABLE_SCROLL];
  assign enable_wrap_x     = ctrl0[TILE_ENABLE_WRAP_X];
  assign enable_wrap_y     = ctrl0[TILE_ENABLE_WRAP_Y];
  assign shift_data_offset = ctrl0[TILE_SHIFT_DATA_OFFSET];

  assign tile_hsize_enum = ctrl1[TILE_HSIZE_1:TILE_HSIZE_0];
  assign tile_vsize_enum = ctrl1[TILE_VSIZE_1:TILE_VSIZE_0];

  // With the shift flag the offset counts in 16-word units, top bits drop off
  always_comb begin
    if (shift_data_offset) begin
      data_offset = vram_addr_t'(data_offset_raw << TILE_DATA_OFFSET_SHIFT);
    end else begin
      data_offset = vram_addr_t'(data_offset_raw);
    end
  end

endmodule

/* tile_reg_file.sv */
// Tile layer register file
`timescale 1ns/100ps

module tile_reg_file #(
  parameter int NUM_LAYERS = tile_pkg::NUM_TILE_LAYERS
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                reg_wr,
  input  tile_pkg::layer_t    reg_layer,
  input  tile_pkg::reg_index_t reg_index,
  input  tile_pkg::reg_data_t reg_wdata,
  output tile_pkg::reg_data_t reg_rdata,
  input  tile_pkg::layer_t    sel_layer,
  output tile_pkg::reg_data_t ctrl0,
  output tile_pkg::reg_data_t ctrl1,
  output tile_pkg::reg_data_t data_offset_raw,
  output tile_pkg::reg_data_t offset_x,
  output tile_pkg::reg_data_t offset_y
);
  import tile_pkg::*;

  reg_data_t regs [NUM_LAYERS][NUM_TILE_REGS];

  // Writes to a missing layer or to index 5..7 fall through and change nothing
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int l = 0; l < NUM_LAYERS; l++) begin
        for (int r = 0; r < NUM_TILE_REGS; r++) begin
          regs[l][r] <= '0;
        end
      end
    end else if (reg_wr && (reg_index < NUM_TILE_REGS)) begin
      for (int l = 0; l < NUM_LAYERS; l++) begin
        if (reg_layer == layer_t'(l)) begin
          regs[l][reg_index] <= reg_wdata;
        end
      end
    end
  end

  // Bus readback, zero for anything that is not a real register
  always_comb begin
    reg_rdata = '0;
    for (int l = 0; l < NUM_LAYERS; l++) begin
      if ((reg_layer == layer_t'(l)) && (reg_index < NUM_TILE_REGS)) begin
        reg_rdata = regs[l][reg_index];
      end
    end
  end

  // The renderer side sees the five words of the requested layer
  always_comb begin
    ctrl0           = '0;
    ctrl1           = '0;
    data_offset_raw = '0;
    offset_x        = '0;
    offset_y        = '0;
    for (int l = 0; l < NUM_LAYERS; l++) begin
      if (sel_layer == layer_t'(l)) begin
        ctrl0           = regs[l][TILE_CTRL0];
        ctrl1           = regs[l][TILE_CTRL1];
        data_offset_raw = regs[l][TILE_DATA_OFFSET];
        offset_x        = regs[l][TILE_OFFSET_X];
        offset_y        = regs[l][TILE_OFFSET_Y];
      end
    end
  end

endmodule
